//--- Bender.yml
package:
  name: pong_display

sources:
  - logic/display_pkg.sv
  - logic/pong_pkg.sv
  - logic/display_timings.sv
  - logic/ball_motion.sv
  - logic/paddle_ai.sv
  - logic/pixel_compose.sv
  - logic/pong_top.sv
  - target: test
    files:
      - verification/pong_asserts.sv
      - verification/pong_checker.sv
      - verification/pong_tb.sv

//--- files.f
logic/display_pkg.sv
logic/pong_pkg.sv
logic/display_timings.sv
logic/ball_motion.sv
logic/paddle_ai.sv
logic/pixel_compose.sv
logic/pong_top.sv
verification/pong_asserts.sv
verification/pong_checker.sv
verification/pong_tb.sv

//--- logic/ball_motion.sv
/*
 * moves the ball by B_SPEED per frame on each axis, bouncing off all edges
 * H_RES and V_RES must exceed B_SIZE + 2*B_SPEED
 */

`timescale 1ns/1ps

module ball_motion #(
    parameter int H_RES   = 1280,
    parameter int V_RES   = 720,
    parameter int B_SIZE  = 16,
    parameter int B_SPEED = 2
) (
    input  logic            clk_pix,
    input  logic            arst_n,
    input  logic            frame_tick,
    output pong_pkg::ball_t ball
);

    pong_pkg::ball_t ball_nxt;

    // one axis of the bounce rule, edge checks take priority over direction
    function automatic void axis_step(
        input  logic [display_pkg::CORDW-1:0]  p,
        input  pong_pkg::dir_e                 d,
        input  int                             res,
        output logic [display_pkg::CORDW-1:0]  p_nxt,
        output pong_pkg::dir_e                 d_nxt
    );
        if (p >= res - (B_SPEED + B_SIZE)) begin    // far edge
            d_nxt = pong_pkg::DIR_BACK;
            p_nxt = p - display_pkg::CORDW'(B_SPEED);
        end else if (p < B_SPEED) begin             // near edge
            d_nxt = pong_pkg::DIR_FWD;
            p_nxt = p + display_pkg::CORDW'(B_SPEED);
        end else begin
            d_nxt = d;
            p_nxt = (d == pong_pkg::DIR_BACK) ? p - display_pkg::CORDW'(B_SPEED)
                                              : p + display_pkg::CORDW'(B_SPEED);
        end
    endfunction

    always_comb begin
        axis_step(ball.x, ball.dx, H_RES, ball_nxt.x, ball_nxt.dx);
        axis_step(ball.y, ball.dy, V_RES, ball_nxt.y, ball_nxt.dy);
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            ball.x  <= display_pkg::CORDW'(H_RES / 2 - B_SIZE / 2);    // centred
            ball.y  <= display_pkg::CORDW'(V_RES / 2 - B_SIZE / 2);
            ball.dx <= pong_pkg::DIR_FWD;
            ball.dy <= pong_pkg::DIR_FWD;
        end else if (frame_tick) begin
            ball <= ball_nxt;
        end
    end

endmodule

//--- logic/display_pkg.sv
/*
 * raster types shared by the timing generator and the drawing logic
 * sync bits are active high, coordinates are unsigned
 */

package display_pkg;

    // wide enough for 1080p totals plus margin
    localparam int CORDW = 12;

    // current raster position
    typedef struct packed {
        logic [CORDW-1:0] sx;    // horizontal, 0 at left of active area
        logic [CORDW-1:0] sy;    // vertical, 0 at top of active area
    } screen_pos_t;

    // sync and data enable, all active high
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;                // high only inside the active area
    } sync_t;

endpackage

//--- logic/display_timings.sv
/*
 * raster counters with active area first, then front porch, sync, back porch
 * outputs are combinational from the counters, sync is active high
 */

`timescale 1ns/1ps

module display_timings #(
    parameter int H_RES  = 1280,
    parameter int H_FP   = 110,
    parameter int H_SYNC = 40,
    parameter int H_BP   = 220,
    parameter int V_RES  = 720,
    parameter int V_FP   = 5,
    parameter int V_SYNC = 5,
    parameter int V_BP   = 20
) (
    input  logic                     clk_pix,
    input  logic                     arst_n,
    output display_pkg::screen_pos_t pos,
    output display_pkg::sync_t       sync,
    output logic                     frame_tick
);

    localparam int H_SYNC_START = H_RES + H_FP;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int H_LAST       = H_SYNC_END + H_BP - 1;    // last pixel of a line
    localparam int V_SYNC_START = V_RES + V_FP;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;
    localparam int V_LAST       = V_SYNC_END + V_BP - 1;    // last line of a frame

    logic [display_pkg::CORDW-1:0] sx;
    logic [display_pkg::CORDW-1:0] sy;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;    // wrap at frame end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    always_comb begin
        pos.sx     = sx;
        pos.sy     = sy;
        sync.de    = (sx < H_RES) && (sy < V_RES);
        sync.hsync = (sx >= H_SYNC_START) && (sx < H_SYNC_END);
        sync.vsync = (sy >= V_SYNC_START) && (sy < V_SYNC_END);
        // one cycle at the start of vertical blanking
        frame_tick = (sy == V_RES) && (sx == 0);
    end

endmodule

//--- logic/paddle_ai.sv
/*
 * both paddles chase the ball centre by P_SP lines per frame
 * a dead band of P_SP/2 around the centre stops them from jittering
 */

`timescale 1ns/1ps

module paddle_ai #(
    parameter int V_RES  = 720,
    parameter int B_SIZE = 16,
    parameter int P_H    = 80,
    parameter int P_SP   = 2
) (
    input  logic               clk_pix,
    input  logic               arst_n,
    input  logic               frame_tick,
    input  pong_pkg::ball_t    ball,
    output pong_pkg::paddles_t paddles
);

    logic [display_pkg::CORDW-1:0] ball_cy;
    pong_pkg::move_e               p1_move;
    pong_pkg::move_e               p2_move;

    // decision for one paddle from its top edge and the ball centre
    function automatic pong_pkg::move_e decide(
        input logic [display_pkg::CORDW-1:0] py,
        input logic [display_pkg::CORDW-1:0] cy
    );
        if ((py + P_H / 2) + P_SP / 2 < cy && py < V_RES - (P_H + P_SP / 2)) begin
            return pong_pkg::MOVE_DOWN;
        end else if ((py + P_H / 2) > cy + P_SP / 2 && py > P_SP) begin
            return pong_pkg::MOVE_UP;
        end
        return pong_pkg::MOVE_HOLD;
    endfunction

    function automatic logic [display_pkg::CORDW-1:0] apply(
        input logic [display_pkg::CORDW-1:0] py,
        input pong_pkg::move_e               mv
    );
        case (mv)
            pong_pkg::MOVE_DOWN: return py + display_pkg::CORDW'(P_SP);
            pong_pkg::MOVE_UP:   return py - display_pkg::CORDW'(P_SP);
            default:             return py;
        endcase
    endfunction

    always_comb begin
        ball_cy = ball.y + display_pkg::CORDW'(B_SIZE / 2);
        p1_move = decide(paddles.p1y, ball_cy);
        p2_move = decide(paddles.p2y, ball_cy);
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            paddles.p1y <= display_pkg::CORDW'(V_RES / 2 - P_H / 2);
            paddles.p2y <= display_pkg::CORDW'(V_RES / 2 - P_H / 2);
        end else if (frame_tick) begin    // uses the pre-update ball
            paddles.p1y <= apply(paddles.p1y, p1_move);
            paddles.p2y <= apply(paddles.p2y, p2_move);
        end
    end

endmodule

//--- logic/pixel_compose.sv
/*
 * white sprites on black, output registered one cycle after the raster
 * sync travels in the same register so colour and sync stay aligned
 */

`timescale 1ns/1ps

module pixel_compose #(
    parameter int H_RES  = 1280,
    parameter int B_SIZE = 16,
    parameter int P_H    = 80,
    parameter int P_W    = 15,
    parameter int P_OFFS = 48
) (
    input  logic                     clk_pix,
    input  logic                     arst_n,
    input  display_pkg::screen_pos_t pos,
    input  display_pkg::sync_t       sync,
    input  pong_pkg::ball_t          ball,
    input  pong_pkg::paddles_t       paddles,
    output pong_pkg::pixel_t         pix
);

    logic b_draw;
    logic p1_draw;
    logic p2_draw;
    logic paint;

    always_comb begin
        b_draw  = (pos.sx >= ball.x) && (pos.sx < ball.x + B_SIZE)
               && (pos.sy >= ball.y) && (pos.sy < ball.y + B_SIZE);
        p1_draw = (pos.sx >= P_OFFS) && (pos.sx < P_OFFS + P_W)    // left paddle
               && (pos.sy >= paddles.p1y) && (pos.sy < paddles.p1y + P_H);
        p2_draw = (pos.sx >= H_RES - P_OFFS - P_W) && (pos.sx < H_RES - P_OFFS)
               && (pos.sy >= paddles.p2y) && (pos.sy < paddles.p2y + P_H);
        paint   = sync.de && (b_draw || p1_draw || p2_draw);    // blank outside active
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            pix <= '0;
        end else begin
            pix.red   <= paint ? 8'hFF : 8'h00;
            pix.green <= paint ? 8'hFF : 8'h00;
            pix.blue  <= paint ? 8'hFF : 8'h00;
            pix.sync  <= sync;
        end
    end

endmodule

//--- logic/pong_pkg.sv
/*
 * game state types for the ball, the paddles and the video output
 * positions are top left corners in screen coordinates
 */

package pong_pkg;

    // motion direction on one axis
    typedef enum logic {
        DIR_FWD  = 1'b0,         // right or down
        DIR_BACK = 1'b1          // left or up
    } dir_e;

    // per-frame paddle decision
    typedef enum logic [1:0] {
        MOVE_HOLD = 2'd0,
        MOVE_UP   = 2'd1,
        MOVE_DOWN = 2'd2
    } move_e;

    typedef struct packed {
        logic [display_pkg::CORDW-1:0] x;
        logic [display_pkg::CORDW-1:0] y;
        dir_e                          dx;
        dir_e                          dy;
    } ball_t;

    typedef struct packed {
        logic [display_pkg::CORDW-1:0] p1y;    // left paddle top
        logic [display_pkg::CORDW-1:0] p2y;    // right paddle top
    } paddles_t;

    typedef struct packed {
        logic [7:0]          red;
        logic [7:0]          green;
        logic [7:0]          blue;
        display_pkg::sync_t  sync;
    } pixel_t;

endpackage

//--- logic/pong_top.sv
/*
 * pong display core, parallel RGB plus sync on the pixel clock
 * defaults give 1280x720 timing, pix lags the raster by one cycle
 */

`timescale 1ns/1ps

module pong_top #(
    parameter int H_RES   = 1280,
    parameter int H_FP    = 110,
    parameter int H_SYNC  = 40,
    parameter int H_BP    = 220,
    parameter int V_RES   = 720,
    parameter int V_FP    = 5,
    parameter int V_SYNC  = 5,
    parameter int V_BP    = 20,
    parameter int B_SIZE  = 16,
    parameter int B_SPEED = 2,
    parameter int P_H     = 80,
    parameter int P_W     = 15,
    parameter int P_SP    = 2,
    parameter int P_OFFS  = 48
) (
    input  logic             clk_pix,
    input  logic             arst_n,
    output pong_pkg::pixel_t pix
);

    display_pkg::screen_pos_t pos;
    display_pkg::sync_t       sync;
    logic                     frame_tick;
    pong_pkg::ball_t          ball;
    pong_pkg::paddles_t       paddles;

    display_timings #(
        .H_RES(H_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_RES(V_RES), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_display_timings (
        .clk_pix, .arst_n, .pos, .sync, .frame_tick
    );

    ball_motion #(
        .H_RES(H_RES), .V_RES(V_RES), .B_SIZE(B_SIZE), .B_SPEED(B_SPEED)
    ) u_ball_motion (
        .clk_pix, .arst_n, .frame_tick, .ball
    );

    paddle_ai #(
        .V_RES(V_RES), .B_SIZE(B_SIZE), .P_H(P_H), .P_SP(P_SP)
    ) u_paddle_ai (
        .clk_pix, .arst_n, .frame_tick, .ball, .paddles
    );

    pixel_compose #(
        .H_RES(H_RES), .B_SIZE(B_SIZE), .P_H(P_H), .P_W(P_W), .P_OFFS(P_OFFS)
    ) u_pixel_compose (
        .clk_pix, .arst_n, .pos, .sync, .ball, .paddles, .pix
    );

endmodule

//--- verification/pong_asserts.sv
/*
 * output properties of the pixel composer, checked only out of reset
 */

`timescale 1ns/1ps

module pong_asserts (
    input logic             clk_pix,
    input logic             arst_n,
    input pong_pkg::pixel_t pix
);

    int fails = 0;

    // blanking stays black
    assert property (@(posedge clk_pix) disable iff (!arst_n)
        !pix.sync.de |-> (pix.red == 8'h00 && pix.green == 8'h00 && pix.blue == 8'h00))
        else begin
            $error("colour is not black while de is low");
            fails++;
        end

    assert property (@(posedge clk_pix) disable iff (!arst_n)
        pix.red == pix.green && pix.green == pix.blue)
        else begin
            $error("colour channels differ");
            fails++;
        end

    assert property (@(posedge clk_pix) disable iff (!arst_n)
        !(pix.sync.hsync && pix.sync.de))
        else begin
            $error("hsync is high inside the active area");
            fails++;
        end

endmodule

bind pixel_compose pong_asserts u_pong_asserts (.clk_pix, .arst_n, .pix);

//--- verification/pong_checker.sv
/*
 * reference model of raster, ball and paddles, compared with pix on every falling edge
 * assumes pix lags the raster by one cycle, defaults match the small test screen
 */

`timescale 1ns/1ps

module pong_checker #(
    parameter int H_RES      = 64,
    parameter int H_FP       = 4,
    parameter int H_SYNC     = 8,
    parameter int H_BP       = 4,
    parameter int V_RES      = 40,
    parameter int V_FP       = 2,
    parameter int V_SYNC     = 2,
    parameter int V_BP       = 2,
    parameter int B_SIZE     = 4,
    parameter int B_SPEED    = 2,
    parameter int P_H        = 10,
    parameter int P_W        = 3,
    parameter int P_SP       = 1,
    parameter int P_OFFS     = 6,
    parameter int NUM_FRAMES = 18
) (
    input  logic             clk_pix,
    input  logic             arst_n,
    input  pong_pkg::pixel_t pix,
    output logic             done,
    output int               tests_run,
    output int               tests_failed
);

    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;
    localparam int N_TESTS = 6;
    localparam int PIXW    = $bits(pong_pkg::pixel_t);

    string names [N_TESTS] = '{"reset_black", "raster_sync", "ball_pixels",
                               "ball_bounce", "paddle_pixels", "black_background"};
    int    errs [N_TESTS]  = '{default: 0};
    int    sx;
    int    sy;
    int    bx;
    int    by;
    int    p1y;
    int    p2y;
    int    cy;
    bit    bdx;                  // 1 means left or up
    bit    bdy;
    bit    was;
    int    flips_x = 0;
    int    flips_y = 0;
    int    holds   = 0;
    int    frames  = 0;
    int    n_failed = 0;
    bit    started = 0;
    bit    reset_done = 0;
    bit    all_done = 0;
    int    exp_test;
    bit    exp_last;
    bit    exp_f1;
    pong_pkg::pixel_t exp_pix;

    assign done         = all_done;
    assign tests_run    = N_TESTS;
    assign tests_failed = n_failed;

    function automatic bit covers(int x, int y, int left, int top, int w, int h);
        return x >= left && x < left + w && y >= top && y < top + h;
    endfunction

    function automatic bit on_paddle(int x, int y);
        return covers(x, y, P_OFFS, p1y, P_W, P_H)
            || covers(x, y, H_RES - P_OFFS - P_W, p2y, P_W, P_H);
    endfunction

    // expected output for raster position x, y with the current game state
    function automatic pong_pkg::pixel_t ref_pixel(int x, int y);
        pong_pkg::pixel_t p;
        bit               lit;
        p.sync.de    = x < H_RES && y < V_RES;
        p.sync.hsync = x >= H_RES + H_FP && x < H_RES + H_FP + H_SYNC;
        p.sync.vsync = y >= V_RES + V_FP && y < V_RES + V_FP + V_SYNC;
        lit          = p.sync.de && (covers(x, y, bx, by, B_SIZE, B_SIZE) || on_paddle(x, y));
        p.red        = lit ? 8'hFF : 8'h00;
        p.green      = lit ? 8'hFF : 8'h00;
        p.blue       = lit ? 8'hFF : 8'h00;
        return p;
    endfunction

    function automatic int pick_test(int x, int y);
        if (x >= H_RES || y >= V_RES) return 5;
        if (covers(x, y, bx, by, B_SIZE, B_SIZE)) return (flips_x + flips_y > 0) ? 3 : 2;
        if (on_paddle(x, y)) return 4;
        return 5;
    endfunction

    // one axis with the edge checks before the current direction
    function automatic int bounce(input int p, input int res, inout bit back);
        if (p >= res - B_SPEED - B_SIZE) back = 1'b1;
        else if (p < B_SPEED) back = 1'b0;
        return back ? p - B_SPEED : p + B_SPEED;
    endfunction

    function automatic int chase(int py, int ball_cy);
        if (py + P_H / 2 + P_SP / 2 < ball_cy && py + P_H + P_SP / 2 < V_RES) return py + P_SP;
        if (py + P_H / 2 > ball_cy + P_SP / 2 && py > P_SP) return py - P_SP;
        return py;
    endfunction

    // paddle centre within half a step of the ball centre
    function automatic bit in_dead_band(int py, int ball_cy);
        return py + P_H / 2 + P_SP / 2 >= ball_cy && py + P_H / 2 <= ball_cy + P_SP / 2;
    endfunction

    task automatic check(int t, logic [PIXW-1:0] expected, logic [PIXW-1:0] actual);
        if (actual !== expected) begin
            errs[t]++;
            $display("** Error %s: expected %h, actual %h", names[t], expected, actual);
        end
    endtask

    task automatic report(int t);
        if (errs[t] != 0) n_failed++;
        $display("test %-16s %s, %0d mismatches", names[t], errs[t] == 0 ? "ok" : "FAILED",
                 errs[t]);
    endtask

    always @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx      = 0;
            sy      = 0;
            bx      = H_RES / 2 - B_SIZE / 2;
            by      = V_RES / 2 - B_SIZE / 2;
            bdx     = 1'b0;
            bdy     = 1'b0;
            p1y     = V_RES / 2 - P_H / 2;
            p2y     = V_RES / 2 - P_H / 2;
            started = 1'b0;
        end else begin
            exp_pix  = ref_pixel(sx, sy);
            exp_test = pick_test(sx, sy);
            exp_last = sx == H_TOTAL - 1 && sy == V_TOTAL - 1;
            exp_f1   = frames == 0;
            if (sy == V_RES && sx == 0) begin    // frame tick uses the old ball for the paddles
                cy = by + B_SIZE / 2;
                if (in_dead_band(p1y, cy) || in_dead_band(p2y, cy)) holds++;
                p1y = chase(p1y, cy);
                p2y = chase(p2y, cy);
                was = bdx;
                bx  = bounce(bx, H_RES, bdx);
                if (bdx != was) flips_x++;
                was = bdy;
                by  = bounce(by, V_RES, bdy);
                if (bdy != was) flips_y++;
            end
            if (sx == H_TOTAL - 1) begin
                sx = 0;
                sy = (sy == V_TOTAL - 1) ? 0 : sy + 1;
            end else begin
                sx++;
            end
            started = 1'b1;
        end
    end

    always @(negedge clk_pix) begin
        if (!started) begin
            if (arst_n === 1'b1) check(0, '0, pix);    // released, first edge still to come
        end else if (!all_done) begin
            if (!reset_done) begin
                report(0);
                reset_done = 1'b1;
            end
            if (exp_f1) check(1, PIXW'(exp_pix.sync), PIXW'(pix.sync));
            check(exp_test, exp_pix, pix);
            if (exp_last) begin
                frames++;
                if (frames == 1) report(1);
                if (frames == NUM_FRAMES) begin
                    if (flips_x == 0 || flips_y == 0) begin
                        errs[3]++;
                        $display("ball_bounce: the ball did not reverse on both axes in the run");
                    end
                    if (holds == 0) begin
                        errs[4]++;
                        $display("paddle_pixels: no frame had a paddle holding in the dead band");
                    end
                    for (int t = 2; t < N_TESTS; t++) report(t);
                    all_done = 1'b1;
                end
            end
        end
    end

endmodule

//--- verification/pong_tb.sv
/*
 * runs the pong core on a 64x40 screen, long enough for the ball to bounce on both axes
 * the checker decides pass or fail, the bound assertions add their own error count
 */

`timescale 1ns/1ps

module pong_tb;

    localparam int NUM_FRAMES  = 18;                                // y bounces at 9, x at 15
    localparam int FRAME_CYC   = 80 * 46;
    localparam int CYCLE_LIMIT = NUM_FRAMES * FRAME_CYC * 6 / 5;    // 20 percent margin

    logic             clk_pix;
    logic             arst_n;
    pong_pkg::pixel_t pix;
    logic             done;
    int               tests_run;
    int               tests_failed;
    int               cycles;

    pong_top #(
        .H_RES(64), .H_FP(4), .H_SYNC(8), .H_BP(4),
        .V_RES(40), .V_FP(2), .V_SYNC(2), .V_BP(2),
        .B_SIZE(4), .B_SPEED(2), .P_H(10), .P_W(3), .P_SP(1), .P_OFFS(6)
    ) u_pong_top (
        .clk_pix, .arst_n, .pix
    );

    pong_checker #(
        .NUM_FRAMES(NUM_FRAMES)
    ) u_checker (
        .clk_pix, .arst_n, .pix, .done, .tests_run, .tests_failed
    );

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;
    end

    initial begin
        arst_n = 1'b0;
        cycles = 0;
        repeat (3) @(posedge clk_pix);
        #2 arst_n = 1'b1;    // release just after an edge
        while (!done && cycles < CYCLE_LIMIT) begin
            @(posedge clk_pix);
            cycles++;
        end
        if (!done) begin
            $display("timeout: checker did not finish within %0d cycles", CYCLE_LIMIT);
        end
        $display("summary: %0d tests, %0d failing, %0d assertion errors, %0d cycles",
                 tests_run, tests_failed, u_pong_top.u_pixel_compose.u_pong_asserts.fails,
                 cycles);
        if (done && tests_failed == 0 && u_pong_top.u_pixel_compose.u_pong_asserts.fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
